// ==== verilog/alu_pkg.sv ====
package alu_pkg;

    // operand width, processed one bit per clock
    localparam int WORD_BITS = 16;

    typedef logic [WORD_BITS-1:0] word_t;

    // serial bit position within a word
    typedef logic [$clog2(WORD_BITS)-1:0] bit_idx_t;

    // OP_LOAD writes the immediate, the rest run through the serial unit
    typedef enum logic [3:0] {
        OP_LOAD = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_XOR  = 4'd3,
        OP_AND  = 4'd4,
        OP_NOT  = 4'd5,  // src_b unused
        OP_OR   = 4'd6,
        OP_NOR  = 4'd7,
        OP_NAND = 4'd8
    } op_t;

endpackage

// ==== verilog/regfile_pkg.sv ====
package regfile_pkg;

    localparam int NUM_REGS = 4;

    typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;

    // one enable bit per storage word
    typedef logic [NUM_REGS-1:0] reg_mask_t;

endpackage

// ==== verilog/cmd_sequencer.sv ====
module cmd_sequencer (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         req,
    input  alu_pkg::op_t op,
    output logic         ack,
    output logic         start,
    output logic         shift,
    output logic         write
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_WRITE,
        ST_ACK
    } state_t;

    state_t state;
    alu_pkg::bit_idx_t bit_cnt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ST_IDLE;
            bit_cnt <= '0;
            ack     <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    bit_cnt <= '0;
                    if (req) begin
                        // immediate load needs no serial pass
                        state <= (op == alu_pkg::OP_LOAD) ? ST_WRITE : ST_RUN;
                    end
                end
                ST_RUN: begin
                    bit_cnt <= bit_cnt + alu_pkg::bit_idx_t'(1);
                    if (bit_cnt == alu_pkg::bit_idx_t'(alu_pkg::WORD_BITS - 1)) begin
                        state <= ST_WRITE;
                    end
                end
                ST_WRITE: begin
                    state <= ST_ACK;
                end
                ST_ACK: begin
                    ack <= req;  // held while host keeps req up
                    if (ack && !req) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    assign shift = (state == ST_RUN);
    assign start = (state == ST_RUN) && (bit_cnt == '0);  // first serial cycle
    assign write = (state == ST_WRITE);

    // ack is registered, so it must already be low once the FSM is back in idle
    a_no_ack_in_idle: assert property (
        @(posedge clk) disable iff (!arst_n)
        (state == ST_IDLE) |-> !ack
    );

endmodule

// ==== verilog/reg_port_ctrl.sv ====
module reg_port_ctrl (
    input  logic                    clk,
    input  logic                    arst_n,
    input  alu_pkg::op_t            op,
    input  regfile_pkg::reg_addr_t  src_a,
    input  regfile_pkg::reg_addr_t  src_b,
    input  regfile_pkg::reg_addr_t  dst,
    input  alu_pkg::word_t          imm,
    input  logic                    shift,
    input  logic                    write,
    input  logic                    res_bit,
    output regfile_pkg::reg_mask_t  load_mask,
    output regfile_pkg::reg_mask_t  shift_mask,
    output alu_pkg::word_t          load_data,
    output alu_pkg::word_t          result
);

    regfile_pkg::reg_mask_t sel_a;
    regfile_pkg::reg_mask_t sel_b;
    regfile_pkg::reg_mask_t sel_dst;
    alu_pkg::word_t         asm_word;

    // one-hot word decode
    assign sel_a   = regfile_pkg::reg_mask_t'(1) << src_a;
    assign sel_b   = regfile_pkg::reg_mask_t'(1) << src_b;
    assign sel_dst = regfile_pkg::reg_mask_t'(1) << dst;

    // both sources rotate, a shared index just rotates once
    assign shift_mask = shift ? (sel_a | sel_b) : '0;
    assign load_mask  = write ? sel_dst : '0;

    assign load_data = (op == alu_pkg::OP_LOAD) ? imm : asm_word;

    // lsb arrives first, enters at the top and walks down
    always_ff @(posedge clk) begin
        if (shift) begin
            asm_word <= {res_bit, asm_word[alu_pkg::WORD_BITS-1:1]};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
        end else if (write) begin
            result <= load_data;  // same value the dst word takes
        end
    end

endmodule

// ==== verilog/word_reg.sv ====
module word_reg (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           load,
    input  logic           shift,
    input  alu_pkg::word_t load_data,
    output alu_pkg::word_t word
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            word <= '0;
        end else if (load) begin
            word <= load_data;
        end else if (shift) begin
            // rotate right, bit 0 wraps to the top
            word <= {word[0], word[alu_pkg::WORD_BITS-1:1]};
        end
    end

    // sequencer never overlaps the write cycle with the serial pass
    a_load_shift_excl: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(load && shift)
    );

    a_hold_when_idle: assert property (
        @(posedge clk) disable iff (!arst_n)
        (!load && !shift) |=> $stable(word)
    );

endmodule

// ==== verilog/operand_select.sv ====
module operand_select (
    input  alu_pkg::word_t         words [regfile_pkg::NUM_REGS],
    input  regfile_pkg::reg_addr_t src_a,
    input  regfile_pkg::reg_addr_t src_b,
    output logic                   a_bit,
    output logic                   b_bit
);

    alu_pkg::word_t word_a;
    alu_pkg::word_t word_b;

    assign word_a = words[src_a];
    assign word_b = words[src_b];

    // bit 0 is the current serial bit of a rotating word
    assign a_bit = word_a[0];
    assign b_bit = word_b[0];

endmodule

// ==== verilog/serial_alu.sv ====
module serial_alu (
    input  logic         clk,
    input  logic         arst_n,
    input  alu_pkg::op_t op,
    input  logic         start,
    input  logic         shift,
    input  logic         a_bit,
    input  logic         b_bit,
    output logic         res_bit,
    output logic         carry
);

    logic is_sub;
    logic is_arith;
    logic b_eff;
    logic c_in;
    logic sum;
    logic c_out;

    assign is_sub   = (op == alu_pkg::OP_SUB);
    assign is_arith = (op == alu_pkg::OP_ADD) || is_sub;

    // a - b = a + ~b + 1
    assign b_eff = b_bit ^ is_sub;
    assign c_in  = start ? is_sub : carry;

    assign sum   = a_bit ^ b_eff ^ c_in;
    assign c_out = (a_bit & b_eff) | (c_in & (a_bit ^ b_eff));

    always_comb begin
        case (op)
            alu_pkg::OP_ADD,
            alu_pkg::OP_SUB:  res_bit = sum;
            alu_pkg::OP_XOR:  res_bit = a_bit ^ b_bit;
            alu_pkg::OP_AND:  res_bit = a_bit & b_bit;
            alu_pkg::OP_NOT:  res_bit = ~a_bit;
            alu_pkg::OP_OR:   res_bit = a_bit | b_bit;
            alu_pkg::OP_NOR:  res_bit = ~(a_bit | b_bit);
            alu_pkg::OP_NAND: res_bit = ~(a_bit & b_bit);
            default:          res_bit = 1'b0;  // load bypasses the unit
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            carry <= 1'b0;
        end else if (shift) begin
            carry <= is_arith ? c_out : 1'b0;  // logic ops leave it clear
        end
    end

endmodule

// ==== verilog/alu_core_top.sv ====
module alu_core_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   req,
    input  alu_pkg::op_t           op,
    input  regfile_pkg::reg_addr_t src_a,
    input  regfile_pkg::reg_addr_t src_b,
    input  regfile_pkg::reg_addr_t dst,
    input  alu_pkg::word_t         imm,
    output logic                   ack,
    output alu_pkg::word_t         result,
    output logic                   carry
);

    logic start;
    logic shift;
    logic write;
    logic a_bit;
    logic b_bit;
    logic res_bit;

    regfile_pkg::reg_mask_t load_mask;
    regfile_pkg::reg_mask_t shift_mask;
    alu_pkg::word_t         load_data;
    alu_pkg::word_t         words [regfile_pkg::NUM_REGS];

    cmd_sequencer i_cmd_sequencer (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .op     (op),
        .ack    (ack),
        .start  (start),
        .shift  (shift),
        .write  (write)
    );

    reg_port_ctrl i_reg_port_ctrl (
        .clk        (clk),
        .arst_n     (arst_n),
        .op         (op),
        .src_a      (src_a),
        .src_b      (src_b),
        .dst        (dst),
        .imm        (imm),
        .shift      (shift),
        .write      (write),
        .res_bit    (res_bit),
        .load_mask  (load_mask),
        .shift_mask (shift_mask),
        .load_data  (load_data),
        .result     (result)
    );

    for (genvar k = 0; k < regfile_pkg::NUM_REGS; k++) begin : g_word
        word_reg i_word_reg (
            .clk       (clk),
            .arst_n    (arst_n),
            .load      (load_mask[k]),
            .shift     (shift_mask[k]),
            .load_data (load_data),
            .word      (words[k])
        );
    end

    operand_select i_operand_select (
        .words (words),
        .src_a (src_a),
        .src_b (src_b),
        .a_bit (a_bit),
        .b_bit (b_bit)
    );

    serial_alu i_serial_alu (
        .clk     (clk),
        .arst_n  (arst_n),
        .op      (op),
        .start   (start),
        .shift   (shift),
        .a_bit   (a_bit),
        .b_bit   (b_bit),
        .res_bit (res_bit),
        .carry   (carry)
    );

endmodule

// ==== verif/tb_alu_core.sv ====
module tb_alu_core;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RAND_CMDS   = 45;
    localparam int NUM_CMDS    = RAND_CMDS + 15;  // 15 directed commands run first
    localparam int CLK_NS      = 100;
    localparam int WATCHDOG_NS = 2 * NUM_CMDS * 20 * CLK_NS;
    localparam int ACK_LIMIT   = alu_pkg::WORD_BITS + 2;

    logic                   clk = 1'b0;
    logic                   arst_n;
    logic                   req;
    alu_pkg::op_t           op;
    regfile_pkg::reg_addr_t src_a;
    regfile_pkg::reg_addr_t src_b;
    regfile_pkg::reg_addr_t dst;
    alu_pkg::word_t         imm;
    logic                   ack;
    alu_pkg::word_t         result;
    logic                   carry;

    logic [15:0]    lfsr;
    alu_pkg::word_t shadow [regfile_pkg::NUM_REGS];  // reference copy of the word bank
    alu_pkg::word_t exp_result;
    logic           exp_carry;
    int             wait_cnt;
    int             value_errs = 0;
    int             hs_errs = 0;

    alu_core_top i_alu_core_top (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .op     (op),
        .src_a  (src_a),
        .src_b  (src_b),
        .dst    (dst),
        .imm    (imm),
        .ack    (ack),
        .result (result),
        .carry  (carry)
    );

    always #(CLK_NS / 2) clk = ~clk;

    // cycles spent waiting on ack
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wait_cnt <= 0;
        end else if (req && !ack) begin
            wait_cnt <= wait_cnt + 1;
        end else begin
            wait_cnt <= 0;
        end
    end

    a_reset_values: assert property (
        @(posedge clk) $rose(arst_n) |-> (!ack && result == '0 && !carry)
    ) else begin
        value_errs = value_errs + 1;
        $display("Mismatch at %0d ns: outputs not cleared by reset", $time);
    end

    a_result: assert property (
        @(posedge clk) disable iff (!arst_n) $rose(ack) |-> (result == exp_result)
    ) else begin
        value_errs = value_errs + 1;
        $display("Mismatch at %0d ns: result %h, expected %h", $time, result, exp_result);
    end

    a_carry: assert property (
        @(posedge clk) disable iff (!arst_n) $rose(ack) |-> (carry == exp_carry)
    ) else begin
        value_errs = value_errs + 1;
        $display("Mismatch at %0d ns: carry %b, expected %b", $time, carry, exp_carry);
    end

    a_ack_in_time: assert property (
        @(posedge clk) disable iff (!arst_n) (req && !ack) |-> (wait_cnt <= ACK_LIMIT)
    ) else begin
        hs_errs = hs_errs + 1;
        $display("ack did not rise within %0d cycles of req (time %0d ns)", ACK_LIMIT, $time);
    end

    a_ack_held: assert property (
        @(posedge clk) disable iff (!arst_n) (ack && req) |=> ack
    ) else begin
        hs_errs = hs_errs + 1;
        $display("ack dropped while req was still high (time %0d ns)", $time);
    end

    a_ack_release: assert property (
        @(posedge clk) disable iff (!arst_n) (ack && !req) |=> !ack
    ) else begin
        hs_errs = hs_errs + 1;
        $display("ack stayed high a cycle after req dropped (time %0d ns)", $time);
    end

    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (!arst_n) (!req && !ack) |=> !ack
    ) else begin
        hs_errs = hs_errs + 1;
        $display("ack rose while req was low (time %0d ns)", $time);
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output alu_pkg::word_t val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[alu_pkg::WORD_BITS-2:0], lfsr[0]};
        end
    endtask

    task automatic predict(input alu_pkg::op_t o, input regfile_pkg::reg_addr_t a,
                           input regfile_pkg::reg_addr_t b, input regfile_pkg::reg_addr_t d,
                           input alu_pkg::word_t imm_v);
        alu_pkg::word_t wa;
        alu_pkg::word_t wb;
        alu_pkg::word_t r;
        logic [16:0]    sum17;
        wa = shadow[a];
        wb = shadow[b];
        r  = '0;
        case (o)
            alu_pkg::OP_LOAD: r = imm_v;  // carry untouched
            alu_pkg::OP_ADD: begin
                sum17     = {1'b0, wa} + {1'b0, wb};
                r         = sum17[15:0];
                exp_carry = sum17[16];
            end
            alu_pkg::OP_SUB: begin
                r         = wa - wb;
                exp_carry = (wa >= wb);  // no borrow
            end
            alu_pkg::OP_XOR:  r = wa ^ wb;
            alu_pkg::OP_AND:  r = wa & wb;
            alu_pkg::OP_NOT:  r = ~wa;
            alu_pkg::OP_OR:   r = wa | wb;
            alu_pkg::OP_NOR:  r = ~(wa | wb);
            alu_pkg::OP_NAND: r = ~(wa & wb);
            default:          r = '0;
        endcase
        if (o != alu_pkg::OP_LOAD && o != alu_pkg::OP_ADD && o != alu_pkg::OP_SUB) begin
            exp_carry = 1'b0;
        end
        exp_result = r;
        shadow[d]  = r;
    endtask

    task automatic run_cmd(input alu_pkg::op_t o, input regfile_pkg::reg_addr_t a,
                           input regfile_pkg::reg_addr_t b, input regfile_pkg::reg_addr_t d,
                           input alu_pkg::word_t imm_v, input int hold);
        predict(o, a, b, d, imm_v);
        op    = o;
        src_a = a;
        src_b = b;
        dst   = d;
        imm   = imm_v;
        req   = 1'b1;
        while (!ack) @(negedge clk);
        repeat (hold) @(negedge clk);  // req kept up past ack
        req = 1'b0;
        while (ack) @(negedge clk);
    endtask

    initial begin
        alu_pkg::word_t opv;
        alu_pkg::word_t av;
        alu_pkg::word_t bv;
        alu_pkg::word_t dv;
        alu_pkg::word_t iv;
        alu_pkg::word_t hv;
        arst_n     = 1'b0;
        req        = 1'b0;
        op         = alu_pkg::OP_LOAD;
        src_a      = '0;
        src_b      = '0;
        dst        = '0;
        imm        = '0;
        lfsr       = 16'd53359;
        exp_result = '0;
        exp_carry  = 1'b0;
        for (int k = 0; k < regfile_pkg::NUM_REGS; k++) begin
            shadow[k] = '0;
        end
        repeat (3) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        run_cmd(alu_pkg::OP_ADD, 0, 1, 2, '0, 0);  // words still at reset value
        for (int k = 0; k < regfile_pkg::NUM_REGS; k++) begin
            take_bits(16, iv);
            run_cmd(alu_pkg::OP_LOAD, 0, 0, regfile_pkg::reg_addr_t'(k), iv, 0);
        end
        for (int k = 1; k <= 8; k++) begin
            run_cmd(alu_pkg::op_t'(k), 0, 1, 3, '0, k % 4);
        end
        // dst overwrites src_a, then src_b is read again
        run_cmd(alu_pkg::OP_ADD, 1, 2, 1, '0, 0);
        run_cmd(alu_pkg::OP_XOR, 2, 0, 3, '0, 0);

        for (int n = 0; n < RAND_CMDS; n++) begin
            take_bits(4, opv);
            take_bits(2, av);
            take_bits(2, bv);
            take_bits(2, dv);
            take_bits(16, iv);
            take_bits(2, hv);
            run_cmd(alu_pkg::op_t'(opv[3:0] % 4'd9), regfile_pkg::reg_addr_t'(av[1:0]),
                    regfile_pkg::reg_addr_t'(bv[1:0]), regfile_pkg::reg_addr_t'(dv[1:0]),
                    iv, int'(hv[1:0]));
        end

        repeat (2) @(negedge clk);
        $display("value errors: %0d, handshake errors: %0d", value_errs, hs_errs);
        if (value_errs == 0 && hs_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: commands did not finish within %0d ns", WATCHDOG_NS);
        $display("value errors: %0d, handshake errors: %0d", value_errs, hs_errs);
        $display("Test failures found");
        $finish;
    end

endmodule

// ==== compile.f ====
verilog/alu_pkg.sv
verilog/regfile_pkg.sv
verilog/cmd_sequencer.sv
verilog/reg_port_ctrl.sv
verilog/word_reg.sv
verilog/operand_select.sv
verilog/serial_alu.sv
verilog/alu_core_top.sv
verif/tb_alu_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with verilator, run, then look for the pass line in the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f compile.f --top-module tb_alu_core -o tb_alu_core
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_alu_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed!" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
